/* hdl/rst_cfg.svh */
// build-time sizing only; domain 0 is always the master domain, and the counter widths follow these values
`ifndef RST_CFG_SVH
`define RST_CFG_SVH

// clock domains incl. master domain 0
`define RST_NUM_DOMAINS 4

// release flops per domain reset chain, at least 2
`define RST_SYNC_STAGES 4

// consecutive master cycles a lock must stay high
`define RST_LOCK_FILTER 16

// master cycles between successive domain releases, at least 1
`define RST_STAGGER_GAP 8

// loss counter width, saturates at all ones
`define RST_LOSS_W 8

`endif

/* hdl/rst_pkg.sv */
// shared sequencer types; vector widths come from rst_cfg.svh and change for every user at once
`default_nettype none

`include "rst_cfg.svh"

package rst_pkg;

    // sequencer states, 2 bits
    typedef enum logic [1:0] {
        SEQ_HOLD      = 2'd0, // in reset, all requests held
        SEQ_WAIT_LOCK = 2'd1, // waiting for every lock to pass the filter
        SEQ_STAGGER   = 2'd2, // releasing domains one by one
        SEQ_RUN       = 2'd3  // all domains out of reset
    } seq_state_e;

    // filtered lock view, lock filter to sequencer
    typedef struct packed {
        logic [`RST_NUM_DOMAINS-1:0] stable;     // per-domain lock passed filter
        logic                        all_stable; // and of stable
    } lock_status_t;

    // sequencer status, exported from the top level
    typedef struct packed {
        seq_state_e                  state;      // current sequencer state
        logic [`RST_NUM_DOMAINS-1:0] released;   // request dropped for this domain
        logic [`RST_LOSS_W-1:0]      loss_count; // lock losses in stagger or run
    } rst_status_t;

endpackage

`default_nettype wire

/* hdl/rst_lock_filter.sv */
// lock flags are async levels; one low sample restarts the full filter window, short highs never pass
`timescale 1ns/1ps
`default_nettype none

`include "rst_cfg.svh"

module rst_lock_filter (
    input  wire logic                        arst,     // master clock
    input  wire logic                        clk,      // async reset, active high
    input  wire logic [`RST_NUM_DOMAINS-1:0] locked,   // raw lock flags, any clock
    output rst_pkg::lock_status_t            lock_stat // filtered lock view
);

    localparam int unsigned N     = `RST_NUM_DOMAINS;
    localparam int unsigned CNT_W = $clog2(`RST_LOCK_FILTER + 1); // holds full count

    logic [N-1:0] stable; // per-domain filter result

    for (genvar i = 0; i < N; i++) begin : g_dom
        logic             meta_q; // first sync flop, may go metastable
        logic             sync_q; // lock on master clock
        logic [CNT_W-1:0] cnt_q;  // consecutive high samples

        // two-flop crossing into the master clock
        always_ff @(posedge arst or posedge clk) begin
            if (clk) begin
                meta_q <= 1'b0;
                sync_q <= 1'b0;
            end else begin
                meta_q <= locked[i];
                sync_q <= meta_q;
            end
        end

        // saturating stability counter
        always_ff @(posedge arst or posedge clk) begin
            if (clk) begin
                cnt_q <= '0;
            end else if (!sync_q) begin
                cnt_q <= '0; // low sample restarts window
            end else if (cnt_q != CNT_W'(`RST_LOCK_FILTER)) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end

        assign stable[i] = (cnt_q == CNT_W'(`RST_LOCK_FILTER)); // saturated means stable
    end

    // all_stable drops the same cycle any single domain drops
    assign lock_stat = '{
        stable:     stable,
        all_stable: &stable
    };

endmodule

`default_nettype wire

/* hdl/rst_sequencer.sv */
// releases domains in index order only; any lock loss during stagger or run restarts the whole sequence
`timescale 1ns/1ps
`default_nettype none

`include "rst_cfg.svh"

module rst_sequencer (
    input  wire logic                        arst,      // master clock
    input  wire logic                        clk,       // async reset, active high
    input  rst_pkg::lock_status_t            lock_stat, // from lock filter
    output logic      [`RST_NUM_DOMAINS-1:0] rst_req,   // 1 holds domain in reset
    output rst_pkg::rst_status_t             status     // state, releases, loss count
);

    localparam int unsigned N     = `RST_NUM_DOMAINS;
    localparam int unsigned IDX_W = (N > 1) ? $clog2(N) : 1;
    localparam int unsigned GAP_W = $clog2(`RST_STAGGER_GAP + 1);

    rst_pkg::seq_state_e    state_q;    // sequencer state
    logic [N-1:0]           released_q; // domains already released
    logic [`RST_LOSS_W-1:0] loss_q;     // saturating loss count
    logic [IDX_W-1:0]       idx_q;      // next domain to release
    logic [GAP_W-1:0]       gap_q;      // cycles left before next release
    logic                   lock_lost;  // lock dropped while releasing or running

    assign lock_lost = !lock_stat.all_stable &&
                       ((state_q == rst_pkg::SEQ_STAGGER) || (state_q == rst_pkg::SEQ_RUN));

    always_ff @(posedge arst or posedge clk) begin
        if (clk) begin
            state_q    <= rst_pkg::SEQ_HOLD;
            released_q <= '0;
            loss_q     <= '0;
            idx_q      <= '0;
            gap_q      <= '0;
        end else if (lock_lost) begin
            state_q    <= rst_pkg::SEQ_WAIT_LOCK; // wait for filter again
            released_q <= '0;                     // every request back up
            idx_q      <= '0;
            gap_q      <= '0;
            if (loss_q != {`RST_LOSS_W{1'b1}}) begin
                loss_q <= loss_q + 1'b1;
            end
        end else begin
            unique case (state_q)
                rst_pkg::SEQ_HOLD: begin
                    state_q <= rst_pkg::SEQ_WAIT_LOCK; // one cycle after reset ends
                end
                rst_pkg::SEQ_WAIT_LOCK: begin
                    if (lock_stat.all_stable) begin
                        state_q <= rst_pkg::SEQ_STAGGER;
                        idx_q   <= '0;
                        gap_q   <= '0; // domain 0 goes on the next cycle
                    end
                end
                rst_pkg::SEQ_STAGGER: begin
                    if (gap_q == '0) begin
                        released_q[idx_q] <= 1'b1;
                        if (idx_q == IDX_W'(N - 1)) begin
                            state_q <= rst_pkg::SEQ_RUN; // last domain out
                        end else begin
                            idx_q <= idx_q + 1'b1;
                            gap_q <= GAP_W'(`RST_STAGGER_GAP - 1);
                        end
                    end else begin
                        gap_q <= gap_q - 1'b1;
                    end
                end
                rst_pkg::SEQ_RUN: begin
                    state_q <= rst_pkg::SEQ_RUN; // hold until a lock drops
                end
                default: begin
                    state_q <= rst_pkg::SEQ_HOLD;
                end
            endcase
        end
    end

    // request is the complement of release, all ones in reset
    assign rst_req = ~released_q;

    assign status = '{
        state:      state_q,
        released:   released_q,
        loss_count: loss_q
    };

endmodule

`default_nettype wire

/* hdl/rst_domain_sync.sv */
// domain clocks must run for a reset to release; assertion needs no clock, domain 0 runs on the master clock
`timescale 1ns/1ps
`default_nettype none

`include "rst_cfg.svh"

module rst_domain_sync (
    input  wire logic                        arst,    // master clock, domain 0
    input  wire logic                        clk,     // async reset, active high
    input  wire logic [`RST_NUM_DOMAINS-1:1] dom_clk, // clocks of domains 1 and up
    input  wire logic [`RST_NUM_DOMAINS-1:0] locked,  // raw lock flags
    input  wire logic [`RST_NUM_DOMAINS-1:0] rst_req, // sequencer hold requests
    output logic      [`RST_NUM_DOMAINS-1:0] rst      // per-domain resets, active high
);

    localparam int unsigned N = `RST_NUM_DOMAINS;
    localparam int unsigned S = `RST_SYNC_STAGES;

    logic [N-1:0] dclk;  // clock per domain, index 0 is master
    logic [N-1:0] cause; // any reason to hold the domain

    assign dclk[0]     = arst;
    assign dclk[N-1:1] = dom_clk;

    for (genvar i = 0; i < N; i++) begin : g_dom
        logic [S-1:0] chain_q; // release shift chain

        // own lock loss forces reset locally without the sequencer
        assign cause[i] = clk | rst_req[i] | ~locked[i];

        always_ff @(posedge dclk[i] or posedge cause[i]) begin
            if (cause[i]) begin
                chain_q <= '1; // assert at once
            end else begin
                chain_q <= {chain_q[S-2:0], 1'b0}; // shift zeros toward the output
            end
        end

        assign rst[i] = chain_q[S-1]; // drops S edges after cause clears
    end

endmodule

`default_nettype wire

/* hdl/rst_ctrl_top.sv */
// arst is the master clock and clk the async reset; locked flags may be async to every clock
`timescale 1ns/1ps
`default_nettype none

`include "rst_cfg.svh"

module rst_ctrl_top (
    input  wire logic                        arst,    // master clock, also domain 0
    input  wire logic                        clk,     // async reset, active high
    input  wire logic [`RST_NUM_DOMAINS-1:1] dom_clk, // domain clocks
    input  wire logic [`RST_NUM_DOMAINS-1:0] locked,  // lock per clock generator
    output logic      [`RST_NUM_DOMAINS-1:0] rst,     // resets, each in its own clock
    output rst_pkg::rst_status_t             status   // sequencer status
);

    rst_pkg::lock_status_t         lock_stat; // filtered locks
    logic [`RST_NUM_DOMAINS-1:0]   rst_req;   // sequencer hold requests

    // input side, lock flags onto master clock
    rst_lock_filter u_lock_filter (
        .arst      (arst),
        .clk       (clk),
        .locked    (locked),
        .lock_stat (lock_stat)
    );

    // staggered release and loss handling
    rst_sequencer u_sequencer (
        .arst      (arst),
        .clk       (clk),
        .lock_stat (lock_stat),
        .rst_req   (rst_req),
        .status    (status)
    );

    // output side, one reset chain per domain
    rst_domain_sync u_domain_sync (
        .arst      (arst),
        .clk       (clk),
        .dom_clk   (dom_clk),
        .locked    (locked),
        .rst_req   (rst_req),
        .rst       (rst)
    );

endmodule

`default_nettype wire

/* test/rst_ctrl_tb.sv */
// assumes four domains with fixed clock periods; lock drops are pseudo-random from a fixed LFSR seed
`timescale 1ns/1ps
`default_nettype none

`include "rst_cfg.svh"

module rst_ctrl_tb;

    localparam int N      = `RST_NUM_DOMAINS;
    localparam int S      = `RST_SYNC_STAGES;
    localparam int FILTER = `RST_LOCK_FILTER;
    localparam int GAP    = `RST_STAGGER_GAP;
    localparam int DOM_W  = (N > 1) ? $clog2(N) : 1; // bits drawn for a domain pick

    logic                 arst;    // master clock
    logic                 clk;     // async active-high reset
    logic [N-1:1]         dom_clk; // domain clocks
    logic [N-1:0]         locked;  // lock flags driven by the testbench
    logic [N-1:0]         rst;     // per-domain resets from DUT
    rst_pkg::rst_status_t status;  // sequencer status from DUT
    logic [N-1:0]         dclk;    // all domain clocks with master at index 0

    int          mismatch_cnt; // wrong values seen
    int          fail_cnt;     // timeouts and monitor errors
    int          cyc;          // master cycles counted on falling edges
    logic [15:0] lfsr;         // random state

    // reference model state
    logic [N-1:0]        m_cross0;  // first crossing stage
    logic [N-1:0]        m_cross1;  // lock as seen on the master clock
    int                  m_run [N]; // consecutive crossed high samples
    logic [N-1:0]        m_stable;
    logic                m_all;
    rst_pkg::seq_state_e m_state;
    logic [N-1:0]        m_rel;     // expected released vector
    logic [7:0]          m_loss;
    int                  m_t;       // cycles spent in stagger

    rst_ctrl_top DUT (
        .arst    (arst),
        .clk     (clk),
        .dom_clk (dom_clk),
        .locked  (locked),
        .rst     (rst),
        .status  (status)
    );

    assign dclk = {dom_clk, arst};

    initial begin
        arst = 1'b0;
        forever #4 arst = ~arst; // 8 ns master
    end

    initial begin
        dom_clk[1] = 1'b0;
        forever #5 dom_clk[1] = ~dom_clk[1]; // 10 ns
    end

    initial begin
        dom_clk[2] = 1'b0;
        forever #7 dom_clk[2] = ~dom_clk[2]; // 14 ns
    end

    initial begin
        dom_clk[3] = 1'b0;
        forever #3 dom_clk[3] = ~dom_clk[3]; // 6 ns
    end

    // 16-bit Fibonacci with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int unsigned val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr); // one step per bit
            val  = (val << 1) | lfsr[0];
        end
    endtask

    task automatic check_state(input string name, input rst_pkg::seq_state_e exp,
                               input rst_pkg::seq_state_e act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("MISMATCH %s expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_released(input string name, input logic [N-1:0] exp,
                                  input logic [N-1:0] act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_loss(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_rst(input string name, input logic [N-1:0] exp,
                             input logic [N-1:0] act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (exp != act) begin
            mismatch_cnt++;
            $display("MISMATCH %s expected %0d cycles actual %0d cycles", name, exp, act);
        end
    endtask

    task automatic model_reset();
        m_cross0 = '0;
        m_cross1 = '0;
        m_stable = '0;
        m_all    = 1'b0;
        m_state  = rst_pkg::SEQ_HOLD;
        m_rel    = '0;
        m_loss   = '0;
        m_t      = 0;
        for (int i = 0; i < N; i++) begin
            m_run[i] = 0;
        end
    endtask

    // one master rising edge with the inputs held over the cycle
    task automatic model_step(input logic [N-1:0] lk, input logic rst_in);
        if (rst_in) begin
            model_reset();
        end else begin
            // sequencer acts on the lock view from before this edge
            if (((m_state == rst_pkg::SEQ_STAGGER) || (m_state == rst_pkg::SEQ_RUN))
                && !m_all) begin
                m_state = rst_pkg::SEQ_WAIT_LOCK; // lock lost restarts the sequence
                m_rel   = '0;
                if (m_loss != 8'hff) begin
                    m_loss++;
                end
            end else if (m_state == rst_pkg::SEQ_HOLD) begin
                m_state = rst_pkg::SEQ_WAIT_LOCK;
            end else if ((m_state == rst_pkg::SEQ_WAIT_LOCK) && m_all) begin
                m_state = rst_pkg::SEQ_STAGGER;
                m_t     = 0;
            end else if (m_state == rst_pkg::SEQ_STAGGER) begin
                m_t++;
                for (int i = 0; i < N; i++) begin
                    if (m_t == 1 + i * GAP) begin
                        m_rel[i] = 1'b1; // domain 0 one cycle in and then every GAP
                    end
                end
                if (m_rel[N-1]) begin
                    m_state = rst_pkg::SEQ_RUN;
                end
            end
            // filter counts samples that finished the 2-cycle crossing
            for (int i = 0; i < N; i++) begin
                if (!m_cross1[i]) begin
                    m_run[i] = 0;
                end else if (m_run[i] < FILTER) begin
                    m_run[i]++;
                end
                m_stable[i] = (m_run[i] == FILTER);
            end
            m_cross1 = m_cross0;
            m_cross0 = lk;
            m_all    = &m_stable;
        end
    endtask

    // wait one master cycle then step the model and compare status
    task automatic tick();
        @(negedge arst);
        cyc++;
        model_step(locked, clk);
        check_state("model_state", m_state, status.state);
        check_released("model_released", m_rel, status.released);
        check_loss("model_loss", m_loss, status.loss_count);
    endtask

    task automatic stop_on_timeout(input string what);
        fail_cnt++;
        $display("ERROR: timed out waiting for %s", what);
        $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        $display("Regression failed");
        $finish;
    endtask

    // follow one staggered release from the cycle the last lock came back
    task automatic run_sequence(input string name, input int ret_cyc);
        int           rise [N]; // cycle each released bit rose
        logic [N-1:0] prev;
        int           n;
        prev = status.released;
        n    = 0;
        for (int i = 0; i < N; i++) begin
            rise[i] = -1;
        end
        while (status.state != rst_pkg::SEQ_RUN) begin
            tick();
            n++;
            for (int i = 0; i < N; i++) begin
                if (status.released[i] && !prev[i]) begin
                    rise[i] = cyc;
                end
            end
            prev = status.released;
            if (n > 200) begin
                stop_on_timeout({name, " sequence to reach run"});
            end
        end
        // 2 crossing + filter + stagger entry + first release
        check_cycles({name, "_first_release"}, FILTER + 4, rise[0] - ret_cyc);
        for (int i = 1; i < N; i++) begin
            check_cycles({name, "_gap"}, GAP, rise[i] - rise[i-1]);
        end
        check_released({name, "_released"}, '1, status.released);
        n = 0;
        while (rst != '0) begin
            tick();
            n++;
            if (n > 20) begin
                stop_on_timeout({name, " domain resets to release"});
            end
        end
    endtask

    task automatic finish_run();
        $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if ((mismatch_cnt == 0) && (fail_cnt == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // per-domain release watch sampled just after the domain's falling edge
    for (genvar i = 0; i < N; i++) begin : g_release_mon
        int edges; // samples with rst still high after release
        initial begin
            edges = 0;
            forever begin
                @(negedge dclk[i]);
                #1;
                if (clk || !status.released[i] || !locked[i]) begin
                    edges = 0;
                    if (!rst[i]) begin
                        fail_cnt++;
                        $display("ERROR: domain %0d left reset without a release", i);
                    end
                end else if (rst[i]) begin
                    edges++;
                    if (edges == S + 2) begin
                        fail_cnt++;
                        $display("ERROR: domain %0d reset still high %0d edges after release",
                                 i, edges);
                    end
                end else begin
                    edges = 0;
                end
            end
        end
    end

    initial begin
        int unsigned  v;
        int           d;
        int           dur;
        int           n;
        int           ret;
        logic         cleared;
        logic [N-1:0] exp_rst;
        logic [7:0]   exp_loss;
        clk          = 1'b1;
        locked       = '0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        cyc          = 0;
        lfsr         = 16'd12749;
        exp_loss     = '0;
        model_reset();

        // power-on reset for 3 master cycles
        repeat (3) begin
            tick();
            check_rst("reset_hold", '1, rst);
        end
        clk    = 1'b0;
        locked = '1;
        ret    = cyc;
        run_sequence("clean", ret);

        // lock loss in run
        for (int it = 0; it < 4; it++) begin
            draw_bits(DOM_W, v);
            d = v % N;
            draw_bits(5, v);
            dur = v + 1; // 1 to 32 cycles low
            exp_loss++;
            locked[d] = 1'b0;
            #0.5;
            exp_rst    = '0;
            exp_rst[d] = 1'b1; // only the lost domain before any edge
            check_rst("loss_async_rst", exp_rst, rst);
            n       = 0;
            cleared = 1'b0;
            while (!cleared || (n < dur)) begin
                tick();
                n++;
                if (status.released == '0) begin
                    cleared = 1'b1;
                end
                if (n == dur) begin
                    locked[d] = 1'b1;
                    ret       = cyc;
                end
                if (n > 100) begin
                    stop_on_timeout("released bits to clear after lock loss");
                end
            end
            check_loss("loss_count", exp_loss, status.loss_count);
            run_sequence("relock", ret);
        end

        // reset in the middle of a run with every lock held high
        clk = 1'b1;
        #0.5;
        check_rst("midrun_reset", '1, rst);
        check_state("midrun_state", rst_pkg::SEQ_HOLD, status.state);
        check_loss("midrun_loss", '0, status.loss_count);
        repeat (3) begin
            tick();
        end
        clk = 1'b0;

        // short glitch before the filter window completes
        draw_bits(3, v);
        repeat (v + 1) begin
            tick();
        end
        draw_bits(DOM_W, v);
        d = v % N;
        draw_bits(4, v);
        dur       = (v % (FILTER - 3)) + 1; // shorter than FILTER - 2
        locked[d] = 1'b0;
        repeat (dur) begin
            tick();
        end
        locked[d] = 1'b1;
        ret       = cyc;
        run_sequence("glitch", ret);

        finish_run();
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/rst_pkg.sv
hdl/rst_lock_filter.sv
hdl/rst_sequencer.sv
hdl/rst_domain_sync.sv
hdl/rst_ctrl_top.sv
test/rst_ctrl_tb.sv

/* Bender.yml */
package:
  name: rst_ctrl

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rst_pkg.sv
      - hdl/rst_lock_filter.sv
      - hdl/rst_sequencer.sv
      - hdl/rst_domain_sync.sv
      - hdl/rst_ctrl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/rst_ctrl_tb.sv
